// ==== all.f ====
src/debug_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_unit.sv
src/instr_mem.sv
src/data_path.sv
src/top.sv
testbench/top_chk.sv
testbench/top_tb.sv

// ==== src/data_path.sv ====
`timescale 1ns/100ps

module data_path (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_cpu_reset,
    input  logic                i_enable,
    input  debug_pkg::word_t    i_instr,
    input  debug_pkg::rb_addr_t i_rb_addr,
    input  debug_pkg::dm_addr_t i_dm_addr,
    output debug_pkg::word_t    o_pc,
    output debug_pkg::word_t    o_rb_data,
    output debug_pkg::word_t    o_dm_data,
    output logic                o_hlt
);
    import debug_pkg::*;

    word_t      pc;
    logic       halt;
    word_t      rb [2**$bits(rb_addr_t)];
    word_t      dm [2**$bits(dm_addr_t)];

    logic [5:0] opcode;
    rb_addr_t   rs;
    rb_addr_t   rt;
    rb_addr_t   rd;
    word_t      imm;
    word_t      rs_val;
    word_t      rt_val;
    word_t      sum;
    dm_addr_t   ea;
    logic       exec;
    logic       clear;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign imm    = {{16{i_instr[15]}}, i_instr[15:0]};

    assign rs_val = (rs == '0) ? '0 : rb[rs];   // r0 reads zero
    assign rt_val = (rt == '0) ? '0 : rb[rt];
    assign sum    = rs_val + ((opcode == OP_ADD) ? rt_val : imm);
    assign ea     = sum[4:0];

    assign exec  = i_enable && !halt;
    assign clear = i_reset || i_cpu_reset;

    always_ff @(posedge i_clock) begin
        if (clear) begin
            pc   <= '0;
            halt <= 1'b0;
        end else if (exec) begin
            if (opcode == OP_HALT)
                halt <= 1'b1;           // PC stays on the HALT
            else
                pc <= pc + 32'd4;
        end
    end

    // Cleared on each load so a dump shows only the new program
    always_ff @(posedge i_clock) begin
        if (clear) begin
            for (int i = 0; i < $size(rb); i++) begin
                rb[i] <= '0;
                dm[i] <= '0;
            end
        end else if (exec) begin
            case (opcode)
                OP_ADDI: rb[rt] <= sum;
                OP_ADD:  rb[rd] <= sum;
                OP_LW:   rb[rt] <= dm[ea];
                OP_SW:   dm[ea] <= rt_val;
                default: ;                  // HALT and unknown opcodes
            endcase
        end
    end

    // Debug read ports
    assign o_rb_data = (i_rb_addr == '0) ? '0 : rb[i_rb_addr];
    assign o_dm_data = dm[i_dm_addr];

    assign o_pc  = pc;
    assign o_hlt = halt;

endmodule

// ==== src/debug_pkg.sv ====
package debug_pkg;

    typedef logic [7:0]  byte_t;        // UART byte, instruction memory byte
    typedef logic [31:0] word_t;        // Data word, register value, PC
    typedef logic [7:0]  im_addr_t;
    typedef logic [4:0]  rb_addr_t;
    typedef logic [4:0]  dm_addr_t;

    localparam int CLKS_PER_BIT = 16;
    localparam int DUMP_REGS    = 8;
    localparam int DUMP_WORDS   = 8;

    // Host command bytes
    localparam byte_t CMD_LOAD = 8'h4C;     // 'L'
    localparam byte_t CMD_RUN  = 8'h43;     // 'C'
    localparam byte_t CMD_STEP = 8'h53;     // 'S'

    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_ADD  = 6'h20;
    localparam logic [5:0] OP_SW   = 6'h2B;
    localparam logic [5:0] OP_LW   = 6'h23;
    localparam logic [5:0] OP_HALT = 6'h3F;

    typedef enum logic [9:0] {
        IDLE      = 10'b00_0000_0001,
        GET_COUNT = 10'b00_0000_0010,
        GET_PROG  = 10'b00_0000_0100,
        RUN       = 10'b00_0000_1000,
        STEP      = 10'b00_0001_0000,
        SEND_PC   = 10'b00_0010_0000,
        SEND_RB   = 10'b00_0100_0000,
        SEND_DM   = 10'b00_1000_0000,
        WAIT_TX   = 10'b01_0000_0000,
        DONE      = 10'b10_0000_0000
    } du_state_t;

endpackage

// ==== src/debug_unit.sv ====
`timescale 1ns/100ps

module debug_unit (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  debug_pkg::byte_t     i_rx_data,
    input  logic                 i_rx_done,
    input  logic                 i_tx_done,
    input  logic                 i_hlt,
    input  debug_pkg::word_t     i_pc,
    input  debug_pkg::word_t     i_rb_data,
    input  debug_pkg::word_t     i_dm_data,
    output debug_pkg::byte_t     o_tx_data,
    output logic                 o_tx_start,
    output logic                 o_im_write,
    output debug_pkg::im_addr_t  o_im_addr,
    output debug_pkg::byte_t     o_im_data,
    output debug_pkg::rb_addr_t  o_rb_addr,
    output debug_pkg::dm_addr_t  o_dm_addr,
    output logic                 o_cpu_enable,
    output logic                 o_cpu_reset,
    output debug_pkg::du_state_t o_state
);
    import debug_pkg::*;

    du_state_t  state;
    logic [9:0] prog_left;      // Program bytes still expected
    logic [4:0] word_idx;       // PC, then registers, then memory words
    logic [1:0] byte_idx;
    logic       last_byte;
    word_t      dump_word;

    function automatic du_state_t send_state(input logic [4:0] idx);
        if (idx == 5'd0)
            return SEND_PC;
        else if (idx <= 5'(DUMP_REGS))
            return SEND_RB;
        else
            return SEND_DM;
    endfunction

    assign last_byte = (byte_idx == 2'd3) && (word_idx == 5'(DUMP_REGS + DUMP_WORDS));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= IDLE;
            prog_left  <= '0;
            word_idx   <= '0;
            byte_idx   <= '0;
            o_im_write <= 1'b0;
            o_im_addr  <= '0;
        end else begin
            o_im_write <= 1'b0;
            if (o_im_write)
                o_im_addr <= o_im_addr + 1'b1;
            case (state)
                IDLE: begin
                    word_idx <= '0;
                    byte_idx <= '0;
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: state <= GET_COUNT;
                            CMD_RUN:  state <= RUN;
                            CMD_STEP: state <= STEP;
                            default:  state <= IDLE;
                        endcase
                    end
                end
                GET_COUNT: begin
                    o_im_addr <= '0;
                    if (i_rx_done) begin
                        prog_left <= {i_rx_data, 2'b00};   // Four bytes per instruction
                        state     <= (i_rx_data == '0) ? DONE : GET_PROG;
                    end
                end
                GET_PROG: begin
                    if (i_rx_done) begin
                        o_im_write <= 1'b1;
                        prog_left  <= prog_left - 1'b1;
                        if (prog_left == 10'd1)
                            state <= DONE;
                    end
                end
                RUN: begin
                    if (i_hlt)
                        state <= SEND_PC;
                end
                STEP: begin
                    state <= SEND_PC;
                end
                SEND_PC, SEND_RB, SEND_DM: begin
                    state <= WAIT_TX;
                end
                WAIT_TX: begin
                    if (i_tx_done) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (last_byte) begin
                            state <= IDLE;
                        end else if (byte_idx == 2'd3) begin
                            word_idx <= word_idx + 1'b1;
                            state    <= send_state(word_idx + 1'b1);
                        end else begin
                            state <= send_state(word_idx);
                        end
                    end
                end
                default: state <= IDLE;     // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == GET_PROG && i_rx_done)
            o_im_data <= i_rx_data;
    end

    assign o_state      = state;
    assign o_cpu_enable = (state == RUN) || (state == STEP);
    assign o_cpu_reset  = (state == DONE);
    assign o_tx_start   = (state == SEND_PC) || (state == SEND_RB) || (state == SEND_DM);

    // Dump read addresses follow the word index
    assign o_rb_addr = word_idx - 5'd1;
    assign o_dm_addr = word_idx - 5'(DUMP_REGS + 1);

    assign dump_word = (state == SEND_PC) ? i_pc :
                       (state == SEND_RB) ? i_rb_data : i_dm_data;
    assign o_tx_data = dump_word[{byte_idx, 3'b000} +: 8];     // LSB first

endmodule

// ==== src/instr_mem.sv ====
`timescale 1ns/100ps

module instr_mem (
    input  logic                i_clock,
    input  logic                i_write,
    input  debug_pkg::im_addr_t i_waddr,
    input  debug_pkg::byte_t    i_wdata,
    input  debug_pkg::im_addr_t i_raddr,
    output debug_pkg::word_t    o_word
);
    import debug_pkg::*;

    byte_t mem [2**$bits(im_addr_t)];

    always_ff @(posedge i_clock) begin
        if (i_write)
            mem[i_waddr] <= i_wdata;
    end

    // Little endian word at the aligned address
    assign o_word = {mem[{i_raddr[7:2], 2'd3}],
                     mem[{i_raddr[7:2], 2'd2}],
                     mem[{i_raddr[7:2], 2'd1}],
                     mem[{i_raddr[7:2], 2'd0}]};

endmodule

// ==== src/top.sv ====
`timescale 1ns/100ps

module top (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_uart_rx,
    output logic                 o_uart_tx,
    output logic                 o_hlt,
    output debug_pkg::du_state_t o_state
);
    import debug_pkg::*;

    byte_t    rx_data;
    logic     rx_done;
    byte_t    tx_data;
    logic     tx_start;
    logic     tx_done;
    logic     im_write;
    im_addr_t im_addr;
    byte_t    im_data;
    word_t    instr;
    rb_addr_t rb_addr;
    dm_addr_t dm_addr;
    logic     cpu_enable;
    logic     cpu_reset;
    word_t    pc;
    word_t    rb_data;
    word_t    dm_data;
    logic     halt;

    uart_rx u_uart_rx (.i_clock(i_clock),
                       .i_reset(i_reset),
                       .i_rx(i_uart_rx),
                       .o_data(rx_data),
                       .o_done(rx_done));

    uart_tx u_uart_tx (.i_clock(i_clock),
                       .i_reset(i_reset),
                       .i_data(tx_data),
                       .i_start(tx_start),
                       .o_tx(o_uart_tx),
                       .o_done(tx_done));

    debug_unit u_debug_unit (.i_clock(i_clock),
                             .i_reset(i_reset),
                             .i_rx_data(rx_data),
                             .i_rx_done(rx_done),
                             .i_tx_done(tx_done),
                             .i_hlt(halt),
                             .i_pc(pc),
                             .i_rb_data(rb_data),
                             .i_dm_data(dm_data),
                             .o_tx_data(tx_data),
                             .o_tx_start(tx_start),
                             .o_im_write(im_write),
                             .o_im_addr(im_addr),
                             .o_im_data(im_data),
                             .o_rb_addr(rb_addr),
                             .o_dm_addr(dm_addr),
                             .o_cpu_enable(cpu_enable),
                             .o_cpu_reset(cpu_reset),
                             .o_state(o_state));

    instr_mem u_instr_mem (.i_clock(i_clock),
                           .i_write(im_write),
                           .i_waddr(im_addr),
                           .i_wdata(im_data),
                           .i_raddr(pc[7:0]),      // Byte address from the PC
                           .o_word(instr));

    data_path u_data_path (.i_clock(i_clock),
                           .i_reset(i_reset),
                           .i_cpu_reset(cpu_reset),
                           .i_enable(cpu_enable),
                           .i_instr(instr),
                           .i_rb_addr(rb_addr),
                           .i_dm_addr(dm_addr),
                           .o_pc(pc),
                           .o_rb_data(rb_data),
                           .o_dm_data(dm_data),
                           .o_hlt(halt));

    assign o_hlt = halt;

endmodule

// ==== src/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic             i_rx,
    output debug_pkg::byte_t o_data,
    output logic             o_done
);
    import debug_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                       state;
    logic [1:0]                      sync;
    logic [$clog2(CLKS_PER_BIT)-1:0] tick_cnt;
    logic [2:0]                      bit_cnt;
    byte_t                           shift;
    logic                            mid_bit;

    assign mid_bit = (tick_cnt == CLKS_PER_BIT - 1);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sync     <= 2'b11;          // Idle line is high
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            sync   <= {sync[0], i_rx};
            o_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (tick_cnt == CLKS_PER_BIT / 2 - 1) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= sync[1] ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (mid_bit) begin
                        o_done <= sync[1];
                        state  <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && mid_bit)
            shift <= {sync[1], shift[7:1]};     // LSB arrives first
        if (state == RX_STOP && mid_bit && sync[1])
            o_data <= shift;
    end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic             i_clock,
    input  logic             i_reset,
    input  debug_pkg::byte_t i_data,
    input  logic             i_start,
    output logic             o_tx,
    output logic             o_done
);
    import debug_pkg::*;

    logic                            busy;
    logic [9:0]                      frame;     // Shifted out from bit 0
    logic [$clog2(CLKS_PER_BIT)-1:0] tick_cnt;
    logic [3:0]                      bit_cnt;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy     <= 1'b0;
            frame    <= '1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_start) begin
                    busy     <= 1'b1;
                    frame    <= {1'b1, i_data, 1'b0};
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else if (tick_cnt == CLKS_PER_BIT - 1) begin
                tick_cnt <= '0;
                frame    <= {1'b1, frame[9:1]};
                if (bit_cnt == 4'd9) begin
                    busy   <= 1'b0;         // End of stop bit
                    o_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign o_tx = frame[0];

endmodule

// ==== testbench/top_chk.sv ====
`timescale 1ns/100ps

module top_chk (
    input logic                 i_clock,
    input logic                 i_reset,
    input debug_pkg::byte_t     i_rx_data,
    input logic                 i_rx_done,
    input logic                 i_tx_done,
    input logic                 i_hlt,
    input logic                 i_tx_start,
    input logic                 i_cpu_enable,
    input debug_pkg::du_state_t i_state
);
    import debug_pkg::*;

    int   fail_count = 0;   // Polled by the testbench
    logic seen_rx;
    logic tx_busy;          // Between tx_start and tx_done
    logic dumping;          // From the first tx_start to the last tx_done

    assign dumping = tx_busy || i_tx_start;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            seen_rx <= 1'b0;
            tx_busy <= 1'b0;
        end else begin
            if (i_rx_done)
                seen_rx <= 1'b1;
            if (i_tx_start)
                tx_busy <= 1'b1;
            else if (i_tx_done)
                tx_busy <= 1'b0;
        end
    end

    idle_until_rx: assert property (@(posedge i_clock) disable iff (i_reset)
        !seen_rx |-> (i_state == IDLE) && !i_hlt && !i_tx_start)
        else begin
            fail_count = fail_count + 1;
            $error("debug unit left its reset condition before the first received byte");
        end

    step_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_state == IDLE) && i_rx_done && (i_rx_data == CMD_STEP)
            |=> i_cpu_enable ##1 !i_cpu_enable)
        else begin
            fail_count = fail_count + 1;
            $error("cpu enable during a step was not a single cycle pulse");
        end

    no_run_in_dump: assert property (@(posedge i_clock) disable iff (i_reset)
        dumping |-> !i_cpu_enable)
        else begin
            fail_count = fail_count + 1;
            $error("cpu enable high while a dump is being sent");
        end

    no_start_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_start |-> !tx_busy)
        else begin
            fail_count = fail_count + 1;
            $error("tx_start issued while the transmitter was busy");
        end

    state_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
        $onehot(i_state))
        else begin
            fail_count = fail_count + 1;
            $error("debug unit state is not one-hot");
        end

endmodule

// ==== testbench/top_tb.sv ====
`timescale 1ns/100ps

module top_tb;
    import debug_pkg::*;

    logic      clock;
    logic      reset;
    logic      uart_rx_line;
    logic      uart_tx_line;
    logic      hlt;
    du_state_t state;

    integer    seed;
    byte_t     dump_bytes [4 * (1 + DUMP_REGS + DUMP_WORDS)];
    word_t     program_a [$];
    word_t     program_b [$];
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] addr_a;
    logic [15:0] addr_b;

    // Reference model state
    byte_t     model_im [256];
    word_t     model_rb [32];
    word_t     model_dm [32];
    word_t     model_pc;
    logic      model_halt;

    top u_top (.i_clock(clock),
               .i_reset(reset),
               .i_uart_rx(uart_rx_line),
               .o_uart_tx(uart_tx_line),
               .o_hlt(hlt),
               .o_state(state));

    bind debug_unit top_chk u_top_chk (.i_clock(i_clock),
                                       .i_reset(i_reset),
                                       .i_rx_data(i_rx_data),
                                       .i_rx_done(i_rx_done),
                                       .i_tx_done(i_tx_done),
                                       .i_hlt(i_hlt),
                                       .i_tx_start(o_tx_start),
                                       .i_cpu_enable(o_cpu_enable),
                                       .i_state(o_state));

    always #5 clock = ~clock;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    always @(negedge clock) begin
        if (u_top.u_debug_unit.u_top_chk.fail_count != 0)
            fail_now("a concurrent assertion in top_chk failed");
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
            else fail_now($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                    name, expected, actual));
    endtask

    function automatic word_t enc_i(input logic [5:0] op, input rb_addr_t rs,
                                    input rb_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_r(input logic [5:0] op, input rb_addr_t rs,
                                    input rb_addr_t rt, input rb_addr_t rd);
        return {op, rs, rt, rd, 11'd0};
    endfunction

    function automatic word_t reg_read(input rb_addr_t idx);
        return (idx == '0) ? '0 : model_rb[idx];
    endfunction

    task automatic model_step();
        im_addr_t   a;
        word_t      instr;
        logic [5:0] op;
        word_t      base;
        word_t      imm;
        word_t      ea;
        if (model_halt)
            return;
        a     = {model_pc[7:2], 2'b00};
        instr = {model_im[a + 8'd3], model_im[a + 8'd2], model_im[a + 8'd1], model_im[a]};
        op    = instr[31:26];
        base  = reg_read(instr[25:21]);
        imm   = {{16{instr[15]}}, instr[15:0]};
        ea    = base + imm;
        case (op)
            OP_ADDI: model_rb[instr[20:16]] = base + imm;
            OP_ADD:  model_rb[instr[15:11]] = base + reg_read(instr[20:16]);
            OP_SW:   model_dm[ea[4:0]] = reg_read(instr[20:16]);
            OP_LW:   model_rb[instr[20:16]] = model_dm[ea[4:0]];
            default: ;
        endcase
        if (op == OP_HALT)
            model_halt = 1'b1;
        else
            model_pc = model_pc + 32'd4;
    endtask

    task automatic model_run();
        for (int i = 0; i < 64 && !model_halt; i++)
            model_step();
    endtask

    // One UART frame, LSB first
    task automatic send_byte(input byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            uart_rx_line <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
    endtask

    task automatic receive_byte(output byte_t data);
        int waited = 0;
        while (uart_tx_line !== 1'b0) begin
            if (waited > 40 * CLKS_PER_BIT)
                fail_now("timeout waiting for a start bit on o_uart_tx");
            waited++;
            @(negedge clock);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clock);     // Middle of the start bit
        if (uart_tx_line !== 1'b0)
            fail_now("start bit on o_uart_tx ended early");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clock);
            data[i] = uart_tx_line;
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        if (uart_tx_line !== 1'b1)
            fail_now("stop bit on o_uart_tx is low");
    endtask

    task automatic receive_dump();
        for (int i = 0; i < $size(dump_bytes); i++)
            receive_byte(dump_bytes[i]);
    endtask

    task automatic wait_idle();
        int waited = 0;
        @(negedge clock);
        while (state != IDLE) begin
            if (waited > 20 * CLKS_PER_BIT)
                fail_now("timeout waiting for the debug unit to return to IDLE");
            waited++;
            @(negedge clock);
        end
    endtask

    // Command and its dump overlap on the two lines
    task automatic run_command(input byte_t cmd);
        fork
            send_byte(cmd);
            receive_dump();
        join
        wait_idle();
    endtask

    function automatic word_t dump_word(input int w);
        return {dump_bytes[4*w+3], dump_bytes[4*w+2], dump_bytes[4*w+1], dump_bytes[4*w]};
    endfunction

    task automatic compare_dump();
        word_t expected;
        string name;
        for (int w = 0; w < 1 + DUMP_REGS + DUMP_WORDS; w++) begin
            if (w == 0) begin
                expected = model_pc;
                name     = "pc";
            end else if (w <= DUMP_REGS) begin
                expected = reg_read(5'(w - 1));
                name     = $sformatf("r%0d", w - 1);
            end else begin
                expected = model_dm[w - 1 - DUMP_REGS];
                name     = $sformatf("dm%0d", w - 1 - DUMP_REGS);
            end
            for (int k = 0; k < 4; k++)
                check_value($sformatf("%s byte %0d", name, k), 32'(expected[8*k +: 8]),
                            32'(dump_bytes[4*w+k]));
        end
    endtask

    task automatic load_program(input word_t prog [$]);
        foreach (model_rb[i]) begin
            model_rb[i] = '0;
            model_dm[i] = '0;       // Loads also clear the data memory
        end
        model_pc   = '0;
        model_halt = 1'b0;
        send_byte(CMD_LOAD);
        send_byte(byte_t'(prog.size()));
        foreach (prog[i]) begin
            for (int k = 0; k < 4; k++) begin
                model_im[4*i+k] = prog[i][8*k +: 8];
                send_byte(prog[i][8*k +: 8]);
            end
        end
        wait_idle();
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        uart_rx_line = 1'b1;
        seed         = 32'h939b;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("o_uart_tx", 32'd1, 32'(uart_tx_line));
        check_value("o_hlt", 32'd0, 32'(hlt));
        check_value("o_state", 32'(IDLE), 32'(state));

        imm_a  = $random(seed);
        imm_b  = $random(seed);
        addr_a = $random(seed) & 7;
        program_a.push_back(enc_i(OP_ADDI, 5'd0, 5'd1, imm_a));
        program_a.push_back(enc_i(OP_ADDI, 5'd0, 5'd2, imm_b));
        program_a.push_back(enc_r(OP_ADD, 5'd1, 5'd2, 5'd3));
        program_a.push_back(enc_i(OP_SW, 5'd0, 5'd3, addr_a));
        program_a.push_back(enc_i(OP_LW, 5'd0, 5'd4, addr_a));
        program_a.push_back(enc_i(OP_HALT, 5'd0, 5'd0, 16'd0));
        load_program(program_a);

        for (int s = 1; s <= 3; s++) begin
            model_step();
            run_command(CMD_STEP);
            compare_dump();
            check_value("dump pc", 32'(4 * s), dump_word(0));
        end
        check_value("o_hlt", 32'd0, 32'(hlt));

        // Run the rest to HALT
        model_run();
        run_command(CMD_RUN);
        compare_dump();
        check_value("o_hlt", 32'd1, 32'(hlt));
        check_value("dump pc", 32'(4 * (program_a.size() - 1)), dump_word(0));

        imm_a  = $random(seed);
        imm_b  = $random(seed);
        addr_b = ($random(seed) & 7) ^ 16'd4;
        program_b.push_back(enc_i(OP_ADDI, 5'd0, 5'd5, imm_a));
        program_b.push_back(enc_i(OP_ADDI, 5'd5, 5'd6, imm_b));
        program_b.push_back(enc_i(OP_SW, 5'd0, 5'd6, addr_b));
        program_b.push_back(enc_i(OP_HALT, 5'd0, 5'd0, 16'd0));
        load_program(program_b);
        check_value("o_hlt", 32'd0, 32'(hlt));

        model_run();
        run_command(CMD_RUN);
        compare_dump();
        check_value("o_hlt", 32'd1, 32'(hlt));
        check_value("dump pc", 32'(4 * (program_b.size() - 1)), dump_word(0));

        @(negedge clock);
        if (u_top.u_debug_unit.u_top_chk.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_now("a concurrent assertion in top_chk failed");
        end
    end

endmodule
